// File: cmd_handshake.sv
`timescale 1ns/1ps
`default_nettype none

// Four-phase req/ack receiver with a one-cycle command pulse
module cmd_handshake (
    input  logic Clock,
    input  logic reset,
    input  logic req,
    output logic ack,
    output logic cmd
);

    logic req_meta;
    logic req_sync;

    // Two-stage synchronizer on the incoming request
    always_ff @(posedge Clock) begin
        if (reset) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
        end else begin
            req_meta <= req;
            req_sync <= req_meta;
        end
    end

    // ack follows the synchronized request
    // cmd marks the cycle where ack first goes high
    always_ff @(posedge Clock) begin
        if (reset) begin
            ack <= 1'b0;
            cmd <= 1'b0;
        end else begin
            ack <= req_sync;
            cmd <= req_sync & ~ack;
        end
    end

endmodule

`default_nettype wire

// File: draw_pkg.sv
`default_nettype none

// Frame-buffer side types
package draw_pkg;

    // 640 columns need 10 bits, 480 rows need 9
    typedef logic [9:0] x_coord_t;
    typedef logic [8:0] y_coord_t;

    typedef logic [8:0] color_t;

    // One pixel write toward the frame buffer
    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
        color_t   color;
        logic     write;
    } pixel_write_t;

endpackage

`default_nettype wire

// File: frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

// Pixel source select by mode, registered toward the frame buffer
module frame_writer (
    input  logic                   Clock,
    input  logic                   reset,
    input  game_pkg::game_mode_t   mode,
    input  draw_pkg::pixel_write_t clear_pixel,
    input  draw_pkg::pixel_write_t missile_pixel,
    output draw_pkg::pixel_write_t pixel
);

    import draw_pkg::*;
    import game_pkg::*;

    pixel_write_t pixel_sel;

    always_comb begin
        case (mode)
            MODE_CLEAR: pixel_sel = clear_pixel;
            MODE_PLAY:  pixel_sel = missile_pixel;
            // Menu leaves the frame buffer alone
            default:    pixel_sel = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            pixel <= '0;
        end else begin
            pixel <= pixel_sel;
        end
    end

endmodule

`default_nettype wire

// File: game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Screen size in pixels
`define SCREEN_COLS 640
`define SCREEN_ROWS 480

// 9-bit colors, 3 bits each of red, green, blue
`define PIXEL_BLACK 9'b000_000_000
`define PIXEL_RED   9'b111_000_000

// Missile rectangle and launch geometry
`define MISSILE_LENGTH    25
`define MISSILE_THICKNESS 3
`define MISSILE_X_OFFSET  16

// Cycles between missile steps
`define MISSILE_STEP_CYCLES 256

// Target box, centered on its position
`define TARGET_WIDTH  32
`define TARGET_HEIGHT 32

`define SCORE_BITS 8

`endif

// File: game_mode_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// Menu, clear and play sequencing
module game_mode_fsm (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 start_cmd,
    input  logic                 clear_done,
    output game_pkg::game_mode_t mode
);

    import game_pkg::*;

    game_mode_t mode_next;

    always_comb begin
        mode_next = mode;
        case (mode)
            MODE_MENU: begin
                if (start_cmd) begin
                    mode_next = MODE_CLEAR;
                end
            end
            MODE_CLEAR: begin
                if (clear_done) begin
                    mode_next = MODE_PLAY;
                end
            end
            // Play holds until reset
            MODE_PLAY: begin
                mode_next = MODE_PLAY;
            end
            default: begin
                mode_next = MODE_MENU;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            mode <= MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

endmodule

`default_nettype wire

// File: game_pkg.sv
`default_nettype none

`include "game_cfg.svh"

// Game-side types
package game_pkg;

    import draw_pkg::*;

    typedef enum logic [1:0] {
        MODE_MENU  = 2'd0,
        MODE_CLEAR = 2'd1,
        MODE_PLAY  = 2'd2
    } game_mode_t;

    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
    } obj_pos_t;

    // Missile top-left corner and flight flag
    typedef struct packed {
        obj_pos_t pos;
        logic     in_flight;
    } missile_status_t;

    typedef logic [`SCORE_BITS-1:0] score_t;

endpackage

`default_nettype wire

// File: missile_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

// Missile flight: draw, wait, erase, step right
module missile_ctrl (
    input  logic                      Clock,
    input  logic                      reset,
    input  game_pkg::game_mode_t      mode,
    input  logic                      fire_cmd,
    input  game_pkg::obj_pos_t        player_pos,
    input  logic                      hit,
    output draw_pkg::pixel_write_t    missile_pixel,
    output game_pkg::missile_status_t missile_status,
    output logic                      launch
);

    import draw_pkg::*;
    import game_pkg::*;

    localparam int XC_BITS   = $clog2(`MISSILE_LENGTH);
    localparam int YC_BITS   = $clog2(`MISSILE_THICKNESS);
    localparam int WAIT_BITS = $clog2(`MISSILE_STEP_CYCLES);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LAUNCH,
        S_DRAW,
        S_WAIT,
        S_ERASE,
        S_MOVE
    } flight_state_t;

    flight_state_t        state;
    flight_state_t        state_next;
    obj_pos_t             pos;
    logic [XC_BITS-1:0]   xc;
    logic [YC_BITS-1:0]   yc;
    logic [WAIT_BITS-1:0] wait_cnt;
    logic                 hit_seen;
    logic                 hit_any;
    logic                 rect_last;
    logic                 wait_last;
    x_coord_t             x_next;

    assign rect_last = (xc == XC_BITS'(`MISSILE_LENGTH - 1)) &&
                       (yc == YC_BITS'(`MISSILE_THICKNESS - 1));
    assign wait_last = (wait_cnt == WAIT_BITS'(`MISSILE_STEP_CYCLES - 1));
    assign x_next    = pos.x + 1'b1;

    // Target dies right after the hit, so the hit is remembered
    assign hit_any = hit_seen | hit;

    // ============================
    // Next state
    // ============================
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (fire_cmd && mode == MODE_PLAY) begin
                    state_next = S_LAUNCH;
                end
            end
            S_LAUNCH: begin
                state_next = S_DRAW;
            end
            S_DRAW: begin
                if (rect_last) begin
                    state_next = S_WAIT;
                end
            end
            S_WAIT: begin
                if (hit_any || wait_last) begin
                    state_next = S_ERASE;
                end
            end
            S_ERASE: begin
                if (rect_last) begin
                    state_next = hit_any ? S_IDLE : S_MOVE;
                end
            end
            S_MOVE: begin
                if (x_next >= x_coord_t'(`SCREEN_COLS)) begin
                    state_next = S_IDLE;
                end else begin
                    state_next = S_DRAW;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    // ============================
    // State and datapath
    // ============================
    always_ff @(posedge Clock) begin
        if (reset) begin
            state    <= S_IDLE;
            pos      <= '0;
            xc       <= '0;
            yc       <= '0;
            wait_cnt <= '0;
            hit_seen <= 1'b0;
        end else begin
            state <= state_next;

            if (state == S_WAIT) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end

            if (state == S_LAUNCH) begin
                hit_seen <= 1'b0;
            end else if (hit) begin
                hit_seen <= 1'b1;
            end

            case (state)
                S_LAUNCH: begin
                    pos.x <= player_pos.x + x_coord_t'(`MISSILE_X_OFFSET);
                    pos.y <= player_pos.y;
                    xc    <= '0;
                    yc    <= '0;
                end
                S_DRAW, S_ERASE: begin
                    // Walk the rectangle, x fastest
                    if (xc == XC_BITS'(`MISSILE_LENGTH - 1)) begin
                        xc <= '0;
                        if (yc == YC_BITS'(`MISSILE_THICKNESS - 1)) begin
                            yc <= '0;
                        end else begin
                            yc <= yc + 1'b1;
                        end
                    end else begin
                        xc <= xc + 1'b1;
                    end
                end
                S_MOVE: begin
                    pos.x <= x_next;
                end
                default: begin
                end
            endcase
        end
    end

    // ============================
    // Outputs
    // ============================
    always_comb begin
        missile_pixel.x     = pos.x + x_coord_t'(xc);
        missile_pixel.y     = pos.y + y_coord_t'(yc);
        missile_pixel.color = (state == S_ERASE) ? `PIXEL_BLACK : `PIXEL_RED;
        missile_pixel.write = (state == S_DRAW) || (state == S_ERASE);

        missile_status.pos       = pos;
        missile_status.in_flight = (state != S_IDLE);
    end

    assign launch = (state == S_LAUNCH);

endmodule

`default_nettype wire

// File: screen_clear.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

// One raster sweep of black pixels after entry into clear mode
module screen_clear (
    input  logic                   Clock,
    input  logic                   reset,
    input  game_pkg::game_mode_t   mode,
    output draw_pkg::pixel_write_t clear_pixel,
    output logic                   clear_done
);

    import draw_pkg::*;
    import game_pkg::*;

    x_coord_t col;
    y_coord_t row;
    logic     active;
    logic     finished;
    logic     col_last;
    logic     row_last;

    assign col_last = (col == x_coord_t'(`SCREEN_COLS - 1));
    assign row_last = (row == y_coord_t'(`SCREEN_ROWS - 1));

    // ============================
    // Raster counters
    // ============================
    always_ff @(posedge Clock) begin
        if (reset) begin
            active   <= 1'b0;
            finished <= 1'b0;
            col      <= '0;
            row      <= '0;
        end else if (active) begin
            if (col_last) begin
                col <= '0;
                if (row_last) begin
                    row      <= '0;
                    active   <= 1'b0;
                    finished <= 1'b1;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end else if (mode == MODE_CLEAR && !finished) begin
            active <= 1'b1;
        end
    end

    // ============================
    // Pixel output
    // ============================
    always_comb begin
        clear_pixel.x     = col;
        clear_pixel.y     = row;
        clear_pixel.color = `PIXEL_BLACK;
        clear_pixel.write = active;
    end

    // Pulses together with the last write
    assign clear_done = active & col_last & row_last;

endmodule

`default_nettype wire

// File: space_shooter.f
+incdir+.
draw_pkg.sv
game_pkg.sv
cmd_handshake.sv
game_mode_fsm.sv
screen_clear.sv
missile_ctrl.sv
target_score.sv
frame_writer.sv
space_shooter_top.sv
tb_space_shooter.sv

// File: space_shooter_top.sv
`timescale 1ns/1ps
`default_nettype none

module space_shooter_top (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   start_req,
    output logic                   start_ack,
    input  logic                   fire_req,
    output logic                   fire_ack,
    input  game_pkg::obj_pos_t     player_pos,
    input  game_pkg::obj_pos_t     target_pos,
    output draw_pkg::pixel_write_t pixel,
    output game_pkg::game_mode_t   mode,
    output game_pkg::score_t       score,
    output logic                   target_alive
);

    import draw_pkg::*;
    import game_pkg::*;

    logic            start_cmd;
    logic            fire_cmd;
    logic            clear_done;
    logic            launch;
    logic            hit;
    pixel_write_t    clear_pixel;
    pixel_write_t    missile_pixel;
    missile_status_t missile_status;

    // ============================
    // Command channels
    // ============================
    cmd_handshake start_hs (
        .Clock (Clock),
        .reset (reset),
        .req   (start_req),
        .ack   (start_ack),
        .cmd   (start_cmd)
    );

    cmd_handshake fire_hs (
        .Clock (Clock),
        .reset (reset),
        .req   (fire_req),
        .ack   (fire_ack),
        .cmd   (fire_cmd)
    );

    // ============================
    // Game blocks
    // ============================
    game_mode_fsm mode_fsm (
        .Clock      (Clock),
        .reset      (reset),
        .start_cmd  (start_cmd),
        .clear_done (clear_done),
        .mode       (mode)
    );

    screen_clear clear0 (
        .Clock       (Clock),
        .reset       (reset),
        .mode        (mode),
        .clear_pixel (clear_pixel),
        .clear_done  (clear_done)
    );

    missile_ctrl missile0 (
        .Clock          (Clock),
        .reset          (reset),
        .mode           (mode),
        .fire_cmd       (fire_cmd),
        .player_pos     (player_pos),
        .hit            (hit),
        .missile_pixel  (missile_pixel),
        .missile_status (missile_status),
        .launch         (launch)
    );

    target_score target0 (
        .Clock          (Clock),
        .reset          (reset),
        .missile_status (missile_status),
        .target_pos     (target_pos),
        .launch         (launch),
        .hit            (hit),
        .score          (score),
        .target_alive   (target_alive)
    );

    frame_writer writer0 (
        .Clock         (Clock),
        .reset         (reset),
        .mode          (mode),
        .clear_pixel   (clear_pixel),
        .missile_pixel (missile_pixel),
        .pixel         (pixel)
    );

endmodule

`default_nettype wire

// File: target_score.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

// Missile against target box, alive flag and score
module target_score (
    input  logic                      Clock,
    input  logic                      reset,
    input  game_pkg::missile_status_t missile_status,
    input  game_pkg::obj_pos_t        target_pos,
    input  logic                      launch,
    output logic                      hit,
    output game_pkg::score_t          score,
    output logic                      target_alive
);

    import game_pkg::*;

    localparam int HALF_W = `TARGET_WIDTH / 2;
    localparam int HALF_H = `TARGET_HEIGHT / 2;

    // One extra bit so the half box can be added without a borrow
    logic [10:0] m_left;
    logic [10:0] m_right;
    logic [9:0]  m_top;
    logic [9:0]  m_bottom;
    logic [10:0] t_x;
    logic [9:0]  t_y;
    logic        overlap;

    assign m_left   = {1'b0, missile_status.pos.x};
    assign m_right  = m_left + 11'(`MISSILE_LENGTH - 1);
    assign m_top    = {1'b0, missile_status.pos.y};
    assign m_bottom = m_top + 10'(`MISSILE_THICKNESS - 1);
    assign t_x      = {1'b0, target_pos.x};
    assign t_y      = {1'b0, target_pos.y};

    // Box spans t - half to t + half - 1, shifted up by half on both sides
    assign overlap = (m_left < t_x + 11'(HALF_W)) && (m_right + 11'(HALF_W) >= t_x) &&
                     (m_top < t_y + 10'(HALF_H)) && (m_bottom + 10'(HALF_H) >= t_y);

    assign hit = missile_status.in_flight & target_alive & overlap;

    // hit drops once alive clears, so each hit scores once
    always_ff @(posedge Clock) begin
        if (reset) begin
            target_alive <= 1'b1;
            score        <= '0;
        end else if (launch) begin
            target_alive <= 1'b1;
        end else if (hit) begin
            target_alive <= 1'b0;
            score        <= score + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: tb_space_shooter.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module tb_space_shooter;

    import draw_pkg::*;
    import game_pkg::*;

    localparam int HS_LIMIT  = 50;
    localparam int RECT_SIZE = `MISSILE_LENGTH * `MISSILE_THICKNESS;

    logic         Clock;
    logic         reset;
    logic         start_req;
    logic         start_ack;
    logic         fire_req;
    logic         fire_ack;
    obj_pos_t     player_pos;
    obj_pos_t     target_pos;
    pixel_write_t pixel;
    game_mode_t   mode;
    score_t       score;
    logic         target_alive;
    integer       seed;

    space_shooter_top dut0 (
        .Clock        (Clock),
        .reset        (reset),
        .start_req    (start_req),
        .start_ack    (start_ack),
        .fire_req     (fire_req),
        .fire_ack     (fire_ack),
        .player_pos   (player_pos),
        .target_pos   (target_pos),
        .pixel        (pixel),
        .mode         (mode),
        .score        (score),
        .target_alive (target_alive)
    );

    always #10 Clock = ~Clock;

    // ==============================
    // Reporting and compare tasks
    // ==============================
    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        abort_run();
    endtask

    task automatic check_pixel(input string name, input pixel_write_t exp,
                               input pixel_write_t act);
        if (act !== exp) begin
            $display("Fail %s: expected x=%0d y=%0d c=%h w=%b, actual x=%0d y=%0d c=%h w=%b",
                     name, exp.x, exp.y, exp.color, exp.write,
                     act.x, act.y, act.color, act.write);
            abort_run();
        end
    endtask

    task automatic check_mode(input string name, input game_mode_t exp, input game_mode_t act);
        if (act !== exp) begin
            $display("Fail %s: expected mode %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            $display("Fail %s: expected score %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_x(input string name, input x_coord_t exp, input x_coord_t act);
        if (act !== exp) begin
            $display("Fail %s: expected column %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic logic ack_of(input bit use_fire);
        return use_fire ? fire_ack : start_ack;
    endfunction

    task automatic drive_req(input bit use_fire, input logic value);
        if (use_fire) begin
            fire_req = value;
        end else begin
            start_req = value;
        end
    endtask

    // Full four-phase cycle starting on a falling edge
    task automatic do_handshake(input string name, input bit use_fire);
        int count;
        drive_req(use_fire, 1'b1);
        count = 0;
        while (!ack_of(use_fire) && count < HS_LIMIT) begin
            @(negedge Clock);
            count++;
        end
        if (!ack_of(use_fire)) report_timeout({name, ": ack did not rise"});
        drive_req(use_fire, 1'b0);
        count = 0;
        while (ack_of(use_fire) && count < HS_LIMIT) begin
            @(negedge Clock);
            count++;
        end
        if (ack_of(use_fire)) report_timeout({name, ": ack did not fall"});
    endtask

    task automatic wait_write(input int limit, output bit found);
        int count;
        count = 0;
        while (!pixel.write && count < limit) begin
            @(negedge Clock);
            count++;
        end
        found = pixel.write;
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            check_bit({name, " no write"}, 1'b0, pixel.write);
            @(negedge Clock);
        end
    endtask

    // Checks one rectangle written pixel by pixel with x fastest
    task automatic expect_rect(input string name, input int rx, input int ry, input color_t color);
        pixel_write_t exp;
        int           i;
        for (i = 0; i < RECT_SIZE; i++) begin
            exp.x     = x_coord_t'(rx + i % `MISSILE_LENGTH);
            exp.y     = y_coord_t'(ry + i / `MISSILE_LENGTH);
            exp.color = color;
            exp.write = 1'b1;
            check_pixel(name, exp, pixel);
            @(negedge Clock);
        end
    endtask

    // Checks every rectangle of one shot on row y0 until writes stop
    task automatic watch_shot(input string name, input int x0, input int y0, output int last_x);
        int rx;
        bit found;
        bit done;
        rx     = x0;
        last_x = x0;
        done   = 1'b0;
        wait_write(2000, found);
        if (!found) report_timeout({name, ": no missile write after fire"});
        check_bit({name, " alive at launch"}, 1'b1, target_alive);
        while (!done) begin
            if (rx >= `SCREEN_COLS) begin
                $display("%s: missile drawn at column %0d, past the screen edge", name, rx);
                abort_run();
            end
            expect_rect(name, rx, y0, `PIXEL_RED);
            wait_write(`MISSILE_STEP_CYCLES + 20, found);
            if (!found) report_timeout({name, ": erase did not follow draw"});
            expect_rect(name, rx, y0, `PIXEL_BLACK);
            last_x = rx;
            wait_write(20, found);
            if (found) begin
                rx = rx + 1;
            end else begin
                done = 1'b1;
            end
        end
    endtask

    task automatic check_clear_sweep(input string name);
        pixel_write_t exp;
        bit           found;
        int           row;
        int           col;
        wait_write(100, found);
        if (!found) report_timeout({name, ": no clear write"});
        check_mode({name, " in clear"}, MODE_CLEAR, mode);
        for (row = 0; row < `SCREEN_ROWS; row++) begin
            for (col = 0; col < `SCREEN_COLS; col++) begin
                exp.x     = x_coord_t'(col);
                exp.y     = y_coord_t'(row);
                exp.color = `PIXEL_BLACK;
                exp.write = 1'b1;
                check_pixel(name, exp, pixel);
                @(negedge Clock);
            end
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    task test_reset_state();
        check_mode("reset mode", MODE_MENU, mode);
        check_bit("reset write", 1'b0, pixel.write);
        check_score("reset score", score_t'(0), score);
        check_bit("reset alive", 1'b1, target_alive);
        check_bit("reset start_ack", 1'b0, start_ack);
        check_bit("reset fire_ack", 1'b0, fire_ack);
        do_handshake("menu fire", 1'b1);
        expect_quiet("menu fire", 1000);
        check_mode("menu fire mode", MODE_MENU, mode);
    endtask

    task test_clear();
        fork
            do_handshake("start", 1'b0);
            check_clear_sweep("clear sweep");
        join
        check_mode("after clear", MODE_PLAY, mode);
        check_bit("after clear write", 1'b0, pixel.write);
    endtask

    task test_missed_shot();
        int px;
        int py;
        int last_x;
        // Target rows lie well below the missile
        px = rand_range(400, 549);
        py = rand_range(20, 199);
        player_pos.x = x_coord_t'(px);
        player_pos.y = y_coord_t'(py);
        target_pos.x = x_coord_t'(rand_range(0, `SCREEN_COLS - 1));
        target_pos.y = y_coord_t'(py + rand_range(100, 199));
        fork
            do_handshake("miss fire", 1'b1);
            watch_shot("miss", px + `MISSILE_X_OFFSET, py, last_x);
        join
        expect_quiet("miss end", 1000);
        check_x("miss last column", x_coord_t'(`SCREEN_COLS - 1), x_coord_t'(last_x));
        check_score("miss score", score_t'(0), score);
    endtask

    task test_hit_shot(input string name, input score_t exp_score);
        int px;
        int py;
        int tx;
        int ty;
        int last_x;
        tx = rand_range(300, 450);
        ty = rand_range(40, 439);
        px = rand_range(100, 199);
        py = ty - 8 + rand_range(0, 11);
        player_pos.x = x_coord_t'(px);
        player_pos.y = y_coord_t'(py);
        target_pos.x = x_coord_t'(tx);
        target_pos.y = y_coord_t'(ty);
        fork
            do_handshake({name, " fire"}, 1'b1);
            watch_shot(name, px + `MISSILE_X_OFFSET, py, last_x);
        join
        expect_quiet({name, " end"}, 1000);
        if (last_x + `MISSILE_LENGTH - 1 > tx - `TARGET_WIDTH / 2 + `MISSILE_LENGTH) begin
            $display("%s: red pixel at column %0d lies too deep inside the target",
                     name, last_x + `MISSILE_LENGTH - 1);
            abort_run();
        end
        check_score({name, " score"}, exp_score, score);
        check_bit({name, " alive"}, 1'b0, target_alive);
    endtask

    task test_fire_during_flight();
        int px;
        int py;
        int last_x;
        px = rand_range(540, 579);
        py = rand_range(20, 199);
        player_pos.x = x_coord_t'(px);
        player_pos.y = y_coord_t'(py);
        target_pos.x = x_coord_t'(rand_range(0, `SCREEN_COLS - 1));
        target_pos.y = y_coord_t'(py + rand_range(100, 199));
        fork
            watch_shot("refire", px + `MISSILE_X_OFFSET, py, last_x);
            begin
                do_handshake("refire first", 1'b1);
                repeat (600) @(negedge Clock);
                // Moved player must not pull the missile along
                player_pos.x = x_coord_t'(10);
                player_pos.y = y_coord_t'(py + 50);
                do_handshake("refire second", 1'b1);
            end
        join
        expect_quiet("refire end", 1000);
        check_x("refire last column", x_coord_t'(`SCREEN_COLS - 1), x_coord_t'(last_x));
        check_score("refire score", score_t'(2), score);
    endtask

    initial begin
        seed        = 42710;
        Clock       = 1'b0;
        reset       = 1'b1;
        start_req   = 1'b0;
        fire_req    = 1'b0;
        player_pos  = '0;
        target_pos  = '0;
        repeat (5) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;

        test_reset_state();
        test_clear();
        test_missed_shot();
        test_hit_shot("first hit", score_t'(1));
        test_hit_shot("second hit", score_t'(2));
        test_fire_during_flight();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
